/* include/rv32_params.svh */
`ifndef RV32_PARAMS_SVH
`define RV32_PARAMS_SVH

// Data path and register file sizes
`define RV_XLEN 32
`define RV_REGS 32

// Decoded operations with one bit each in the op vector
`define RV_OPS 27

// Major opcodes in instr[6:0]
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OPIMM  7'b0010011
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_BRANCH 7'b1100011

// funct7 values
`define RV_F7_BASE 7'b0000000
// SUB and SRA/SRAI
`define RV_F7_ALT  7'b0100000

`endif

/* logic/rv32Pkg.sv */
`include "rv32_params.svh"

package rv32Pkg;

    ////////////////////////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////////////////////////

    typedef logic [`RV_XLEN-1:0]         word_t;
    typedef logic [$clog2(`RV_REGS)-1:0] regIdx_t;
    typedef logic [`RV_OPS-1:0]          opVec_t;

    // Bit position of each operation inside opVec_t
    typedef enum logic [4:0] {
        OP_ADD = 5'd0,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_ADDI,
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_ORI,
        OP_ANDI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_LUI,
        OP_AUIPC,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU
    } opBit_e;

    ////////////////////////////////////////////////////////////
    // Structs between the stages
    ////////////////////////////////////////////////////////////

    // Decoder output with a zero op for an unknown word
    typedef struct packed {
        opVec_t  op;
        word_t   imm;
        regIdx_t rs1;
        regIdx_t rs2;
        regIdx_t rd;
        word_t   pc;
    } decoded_t;

    // Register write from the ALU
    typedef struct packed {
        logic    en;
        regIdx_t rd;
        word_t   data;
    } writeBack_t;

endpackage

/* logic/instrDecoder.sv */
`timescale 1ns/100ps
`include "rv32_params.svh"

module instrDecoder (
    input  rv32Pkg::word_t    instr,
    input  rv32Pkg::word_t    pc,
    output rv32Pkg::decoded_t dec
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    rv32Pkg::opVec_t opVec;
    rv32Pkg::word_t  immVal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    ////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////

    always_comb begin
        opVec = '0;
        case (opcode)
            `RV_OPC_OP: begin
                case ({funct7, funct3})
                    {`RV_F7_BASE, 3'b000}: opVec[rv32Pkg::OP_ADD]  = 1'b1;
                    {`RV_F7_ALT,  3'b000}: opVec[rv32Pkg::OP_SUB]  = 1'b1;
                    {`RV_F7_BASE, 3'b001}: opVec[rv32Pkg::OP_SLL]  = 1'b1;
                    {`RV_F7_BASE, 3'b010}: opVec[rv32Pkg::OP_SLT]  = 1'b1;
                    {`RV_F7_BASE, 3'b011}: opVec[rv32Pkg::OP_SLTU] = 1'b1;
                    {`RV_F7_BASE, 3'b100}: opVec[rv32Pkg::OP_XOR]  = 1'b1;
                    {`RV_F7_BASE, 3'b101}: opVec[rv32Pkg::OP_SRL]  = 1'b1;
                    {`RV_F7_ALT,  3'b101}: opVec[rv32Pkg::OP_SRA]  = 1'b1;
                    {`RV_F7_BASE, 3'b110}: opVec[rv32Pkg::OP_OR]   = 1'b1;
                    {`RV_F7_BASE, 3'b111}: opVec[rv32Pkg::OP_AND]  = 1'b1;
                    default: ;
                endcase
            end
            `RV_OPC_OPIMM: begin
                case (funct3)
                    3'b000: opVec[rv32Pkg::OP_ADDI]  = 1'b1;
                    3'b010: opVec[rv32Pkg::OP_SLTI]  = 1'b1;
                    3'b011: opVec[rv32Pkg::OP_SLTIU] = 1'b1;
                    3'b100: opVec[rv32Pkg::OP_XORI]  = 1'b1;
                    3'b110: opVec[rv32Pkg::OP_ORI]   = 1'b1;
                    3'b111: opVec[rv32Pkg::OP_ANDI]  = 1'b1;
                    // Shift immediates carry funct7 in the upper imm bits
                    3'b001: begin
                        if (funct7 == `RV_F7_BASE) begin
                            opVec[rv32Pkg::OP_SLLI] = 1'b1;
                        end
                    end
                    3'b101: begin
                        if (funct7 == `RV_F7_BASE) begin
                            opVec[rv32Pkg::OP_SRLI] = 1'b1;
                        end else if (funct7 == `RV_F7_ALT) begin
                            opVec[rv32Pkg::OP_SRAI] = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            `RV_OPC_LUI:   opVec[rv32Pkg::OP_LUI]   = 1'b1;
            `RV_OPC_AUIPC: opVec[rv32Pkg::OP_AUIPC] = 1'b1;
            `RV_OPC_BRANCH: begin
                case (funct3)
                    3'b000: opVec[rv32Pkg::OP_BEQ]  = 1'b1;
                    3'b001: opVec[rv32Pkg::OP_BNE]  = 1'b1;
                    3'b100: opVec[rv32Pkg::OP_BLT]  = 1'b1;
                    3'b101: opVec[rv32Pkg::OP_BGE]  = 1'b1;
                    3'b110: opVec[rv32Pkg::OP_BLTU] = 1'b1;
                    3'b111: opVec[rv32Pkg::OP_BGEU] = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Immediate formats
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            // I-type
            `RV_OPC_OPIMM:  immVal = {{20{instr[31]}}, instr[31:20]};
            // B-type with bit 0 always zero
            `RV_OPC_BRANCH: immVal = {{19{instr[31]}}, instr[31], instr[7],
                                      instr[30:25], instr[11:8], 1'b0};
            // U-type
            `RV_OPC_LUI,
            `RV_OPC_AUIPC:  immVal = {instr[31:12], 12'b0};
            default:        immVal = '0;
        endcase
    end

    always_comb begin
        dec.op  = opVec;
        dec.imm = immVal;
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd  = instr[11:7];
        dec.pc  = pc;
    end

endmodule

/* logic/regFile.sv */
`timescale 1ns/100ps
`include "rv32_params.svh"

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  rv32Pkg::regIdx_t    rs1,
    input  rv32Pkg::regIdx_t    rs2,
    input  rv32Pkg::writeBack_t wb,
    output rv32Pkg::word_t      rs1Data,
    output rv32Pkg::word_t      rs2Data
);

    // No storage for x0
    rv32Pkg::word_t regs [1:`RV_REGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Pending write wins over the stored value
    function automatic rv32Pkg::word_t readPort(input rv32Pkg::regIdx_t idx);
        rv32Pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb.en && (wb.rd == idx)) begin
            val = wb.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    assign rs1Data = readPort(rs1);
    assign rs2Data = readPort(rs2);

endmodule

/* logic/aluUnit.sv */
`timescale 1ns/100ps

module aluUnit (
    input  logic                clk,
    input  logic                rst,
    input  logic                instValid,
    input  rv32Pkg::decoded_t   dec,
    input  rv32Pkg::word_t      rs1Data,
    input  rv32Pkg::word_t      rs2Data,
    output rv32Pkg::writeBack_t wb,
    output logic                resultValid,
    output rv32Pkg::word_t      result,
    output rv32Pkg::regIdx_t    resultRd,
    output logic                branchValid,
    output logic                branchTaken,
    output rv32Pkg::word_t      branchTarget,
    output logic                illegal
);

    logic               useImm;
    logic               isAlu;
    logic               isBranch;
    rv32Pkg::word_t     opB;
    logic [4:0]         shamt;
    logic signed [32:0] diffS;
    logic [32:0]        diffU;
    logic               ltS;
    logic               ltU;
    logic               eq;
    rv32Pkg::word_t     aluRes;
    logic               taken;

    ////////////////////////////////////////////////////////////
    // Operand select and compares
    ////////////////////////////////////////////////////////////

    // ADDI through SRAI take the immediate
    assign useImm   = |dec.op[rv32Pkg::OP_SRAI:rv32Pkg::OP_ADDI];
    assign isAlu    = |dec.op[rv32Pkg::OP_AUIPC:rv32Pkg::OP_ADD];
    assign isBranch = |dec.op[rv32Pkg::OP_BGEU:rv32Pkg::OP_BEQ];

    assign opB   = useImm ? dec.imm : rs2Data;
    assign shamt = opB[4:0];

    // Sign or zero extend to 33 bits so the borrow gives the compare
    assign diffS = $signed({rs1Data[31], rs1Data}) - $signed({opB[31], opB});
    assign diffU = {1'b0, rs1Data} - {1'b0, opB};
    assign ltS   = diffS[32];
    assign ltU   = diffU[32];
    assign eq    = (rs1Data == opB);

    always_comb begin
        case (1'b1)
            dec.op[rv32Pkg::OP_ADD],
            dec.op[rv32Pkg::OP_ADDI]:  aluRes = rs1Data + opB;
            dec.op[rv32Pkg::OP_SUB]:   aluRes = diffU[31:0];
            dec.op[rv32Pkg::OP_SLL],
            dec.op[rv32Pkg::OP_SLLI]:  aluRes = rs1Data << shamt;
            dec.op[rv32Pkg::OP_SLT],
            dec.op[rv32Pkg::OP_SLTI]:  aluRes = {31'b0, ltS};
            dec.op[rv32Pkg::OP_SLTU],
            dec.op[rv32Pkg::OP_SLTIU]: aluRes = {31'b0, ltU};
            dec.op[rv32Pkg::OP_XOR],
            dec.op[rv32Pkg::OP_XORI]:  aluRes = rs1Data ^ opB;
            dec.op[rv32Pkg::OP_SRL],
            dec.op[rv32Pkg::OP_SRLI]:  aluRes = rs1Data >> shamt;
            dec.op[rv32Pkg::OP_SRA],
            dec.op[rv32Pkg::OP_SRAI]:  aluRes = $unsigned($signed(rs1Data) >>> shamt);
            dec.op[rv32Pkg::OP_OR],
            dec.op[rv32Pkg::OP_ORI]:   aluRes = rs1Data | opB;
            dec.op[rv32Pkg::OP_AND],
            dec.op[rv32Pkg::OP_ANDI]:  aluRes = rs1Data & opB;
            dec.op[rv32Pkg::OP_LUI]:   aluRes = dec.imm;
            dec.op[rv32Pkg::OP_AUIPC]: aluRes = dec.pc + dec.imm;
            default:                   aluRes = '0;
        endcase
    end

    // Branch condition where opB is rs2Data
    always_comb begin
        case (1'b1)
            dec.op[rv32Pkg::OP_BEQ]:  taken = eq;
            dec.op[rv32Pkg::OP_BNE]:  taken = !eq;
            dec.op[rv32Pkg::OP_BLT]:  taken = ltS;
            dec.op[rv32Pkg::OP_BGE]:  taken = !ltS;
            dec.op[rv32Pkg::OP_BLTU]: taken = ltU;
            dec.op[rv32Pkg::OP_BGEU]: taken = !ltU;
            default:                  taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            branchValid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            resultValid <= instValid && isAlu;
            branchValid <= instValid && isBranch;
            // Zero op vector means an unknown encoding
            illegal     <= instValid && !isAlu && !isBranch;
        end
    end

    always_ff @(posedge clk) begin
        result       <= aluRes;
        resultRd     <= dec.rd;
        branchTaken  <= taken;
        branchTarget <= dec.pc + dec.imm;
    end

    // Write back follows the result strobe and x0 is dropped in the file
    assign wb.en   = resultValid;
    assign wb.rd   = resultRd;
    assign wb.data = result;

endmodule

/* logic/execCore.sv */
`timescale 1ns/100ps

module execCore (
    input  logic             clk,
    input  logic             rst,
    input  logic             instValid,
    input  rv32Pkg::word_t   instr,
    input  rv32Pkg::word_t   pc,
    output logic             resultValid,
    output rv32Pkg::word_t   result,
    output rv32Pkg::regIdx_t resultRd,
    output logic             branchValid,
    output logic             branchTaken,
    output rv32Pkg::word_t   branchTarget,
    output logic             illegal
);

    rv32Pkg::decoded_t   dec;
    rv32Pkg::writeBack_t wb;
    rv32Pkg::word_t      rs1Data;
    rv32Pkg::word_t      rs2Data;

    ////////////////////////////////////////////////////////////
    // Decode and operand read in the same cycle as instValid
    ////////////////////////////////////////////////////////////

    instrDecoder iDecoder (
        .instr (instr),
        .pc    (pc),
        .dec   (dec)
    );

    regFile iRegFile (
        .clk     (clk),
        .rst     (rst),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .wb      (wb),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    // Execute with outputs one cycle later
    aluUnit iAlu (
        .clk          (clk),
        .rst          (rst),
        .instValid    (instValid),
        .dec          (dec),
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .wb           (wb),
        .resultValid  (resultValid),
        .result       (result),
        .resultRd     (resultRd),
        .branchValid  (branchValid),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .illegal      (illegal)
    );

endmodule

/* bench/execCore_assert.sv */
`timescale 1ns/100ps

module execCoreAssert (
    input logic clk,
    input logic rst,
    input logic instValid,
    input logic resultValid,
    input logic branchValid,
    input logic illegal
);

    // Only one kind of outcome per cycle
    strobeExclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({resultValid, branchValid, illegal}))
        else $error("more than one output strobe high");

    // Every strobe answers an instValid one cycle back
    strobeFollowsIssue: assert property (@(posedge clk) disable iff (rst)
        (resultValid || branchValid || illegal) |-> $past(instValid))
        else $error("output strobe without an instruction one cycle earlier");

    // Strobes cleared by the synchronous reset
    strobeLowInReset: assert property (@(posedge clk)
        $past(rst) |-> !(resultValid || branchValid || illegal))
        else $error("output strobe high during reset");

endmodule

bind execCore execCoreAssert iAssert (
    .clk         (clk),
    .rst         (rst),
    .instValid   (instValid),
    .resultValid (resultValid),
    .branchValid (branchValid),
    .illegal     (illegal)
);

/* bench/execCoreTb.sv */
`timescale 1ns/100ps
`include "rv32_params.svh"

module execCoreTb;

    localparam int N_RAND    = 400;
    localparam int N_UPPER   = 40;
    localparam int N_CHAIN   = 200;
    localparam int N_BRANCH  = 200;
    localparam int N_ILLEGAL = 60;
    localparam int MAX_GAP   = 2;
    localparam int STIM = (32 + 62 + N_RAND + N_UPPER + N_CHAIN + N_BRANCH + N_ILLEGAL + 64)
                          * (MAX_GAP + 1) + 40;
    localparam int TIMEOUT = 2 * STIM + 100;

    // Strobe pattern {resultValid, branchValid, illegal}
    typedef struct packed {
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        taken;
        logic [31:0] target;
        logic [31:0] due;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        instValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        resultValid;
    logic [31:0] result;
    logic [4:0]  resultRd;
    logic        branchValid;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic        illegal;

    logic [31:0] modelRegs [32];
    expect_t     expQ [$];
    int unsigned cycleCount = 0;
    int unsigned errorCount = 0;
    int unsigned passCount = 0;

    execCore i_dut (
        .clk          (clk),
        .rst          (rst),
        .instValid    (instValid),
        .instr        (instr),
        .pc           (pc),
        .resultValid  (resultValid),
        .result       (result),
        .resultRd     (resultRd),
        .branchValid  (branchValid),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .illegal      (illegal)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Code order add sub sll slt sltu xor srl sra or and
    function automatic logic [31:0] aluModel(input int code, input logic [31:0] a,
                                             input logic [31:0] b);
        case (code)
            0: return a + b;
            1: return a - b;
            2: return a << b[4:0];
            3: return {31'b0, $signed(a) < $signed(b)};
            4: return {31'b0, a < b};
            5: return a ^ b;
            6: return a >> b[4:0];
            7: return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            8: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [2:0] funct3Of(input int code);
        case (code)
            0, 1: return 3'b000;
            2: return 3'b001;
            3: return 3'b010;
            4: return 3'b011;
            5: return 3'b100;
            6, 7: return 3'b101;
            8: return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [4:0] randReg();
        return 5'($urandom % 32);
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
        end else begin
            passCount++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic issue(input logic [31:0] word, input logic [31:0] pcVal,
                         input expect_t e, input int gapMax);
        int gap;
        gap = (gapMax > 0) ? int'($urandom % (gapMax + 1)) : 0;
        repeat (gap) begin
            @(posedge clk);
            instValid <= 1'b0;
        end
        @(posedge clk);
        instValid <= 1'b1;
        instr     <= word;
        pc        <= pcVal;
        e.due = cycleCount + 1;
        expQ.push_back(e);
    endtask

    task automatic drain();
        @(posedge clk);
        instValid <= 1'b0;
        while (expQ.size() > 0) begin
            @(negedge clk);
        end
    endtask

    task automatic issueAlu(input int code, input bit useImm, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [11:0] imm12, input int gapMax);
        logic [31:0] b;
        logic [31:0] word;
        logic [6:0]  f7;
        expect_t     e;
        f7 = (code == 1 || code == 7) ? 7'h20 : 7'h00;
        if (useImm) begin
            // Shift immediates carry funct7 above the shift amount
            if (code == 2 || code == 6 || code == 7) begin
                imm12 = {f7, imm12[4:0]};
            end
            b = {{20{imm12[11]}}, imm12};
            word = {imm12, rs1, funct3Of(code), rd, `RV_OPC_OPIMM};
        end else begin
            b = modelRegs[rs2];
            word = {f7, rs2, rs1, funct3Of(code), rd, `RV_OPC_OP};
        end
        e = '0;
        e.kind = 3'b100;
        e.rd = rd;
        e.value = aluModel(code, modelRegs[rs1], b);
        if (rd != 0) modelRegs[rd] = e.value;
        issue(word, $urandom, e, gapMax);
    endtask

    task automatic issueUpper(input bit auipc, input logic [4:0] rd,
                              input logic [19:0] imm20, input int gapMax);
        logic [31:0] pcVal;
        expect_t     e;
        pcVal = $urandom;
        e = '0;
        e.kind = 3'b100;
        e.rd = rd;
        e.value = auipc ? pcVal + {imm20, 12'b0} : {imm20, 12'b0};
        if (rd != 0) modelRegs[rd] = e.value;
        issue({imm20, rd, auipc ? `RV_OPC_AUIPC : `RV_OPC_LUI}, pcVal, e, gapMax);
    endtask

    task automatic issueBranch(input int sel, input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [12:0] imm13, input int gapMax);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pcVal;
        logic [2:0]  f3;
        expect_t     e;
        a = modelRegs[rs1];
        b = modelRegs[rs2];
        pcVal = $urandom;
        imm13[0] = 1'b0;
        e = '0;
        e.kind = 3'b010;
        e.target = pcVal + {{19{imm13[12]}}, imm13};
        case (sel)
            0: begin f3 = 3'b000; e.taken = (a == b); end
            1: begin f3 = 3'b001; e.taken = (a != b); end
            2: begin f3 = 3'b100; e.taken = ($signed(a) < $signed(b)); end
            3: begin f3 = 3'b101; e.taken = ($signed(a) >= $signed(b)); end
            4: begin f3 = 3'b110; e.taken = (a < b); end
            default: begin f3 = 3'b111; e.taken = (a >= b); end
        endcase
        issue({imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], `RV_OPC_BRANCH},
              pcVal, e, gapMax);
    endtask

    task automatic issueIllegal(input int gapMax);
        logic [31:0] r;
        logic [31:0] word;
        expect_t     e;
        r = $urandom;
        case ($urandom % 3)
            // Load opcode, MUL funct7, reserved branch funct3
            0: word = {r[31:7], 7'b0000011};
            1: word = {7'h01, r[17:0], `RV_OPC_OP};
            default: word = {r[31:15], 3'b010, r[11:7], `RV_OPC_BRANCH};
        endcase
        e = '0;
        e.kind = 3'b001;
        issue(word, $urandom, e, gapMax);
    endtask

    // ADDI x0, xr, 0 shows each register without changing any
    task automatic readBackAll();
        for (int r = 0; r < 32; r++) begin
            issueAlu(0, 1'b1, 5'd0, 5'(r), 5'd0, 12'd0, 1);
        end
    endtask

    task automatic reportTest(input string name, input int unsigned errBefore);
        $display("Test %s finished with %0d errors", name, errorCount - errBefore);
    endtask

    ////////////////////////////////////////////////////////////
    // Output checker and timeout
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        expect_t e;
        if (!rst) begin
            if (expQ.size() > 0 && expQ[0].due == cycleCount) begin
                e = expQ.pop_front();
                checkValue({29'b0, resultValid, branchValid, illegal}, {29'b0, e.kind},
                           "strobe pattern");
                if (e.kind == 3'b100) begin
                    checkValue(result, e.value, "result");
                    checkValue({27'b0, resultRd}, {27'b0, e.rd}, "resultRd");
                end else if (e.kind == 3'b010) begin
                    checkValue({31'b0, branchTaken}, {31'b0, e.taken}, "branchTaken");
                    checkValue(branchTarget, e.target, "branchTarget");
                end
            end else begin
                checkValue({29'b0, resultValid, branchValid, illegal}, 32'd0,
                           "strobe without instruction");
            end
        end
        cycleCount++;
        if (cycleCount > TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        int unsigned errBefore;
        int          code;
        logic [4:0]  prev;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        void'($urandom(32'h7eab_b222));
        rst = 1'b1;
        instValid = 1'b0;
        instr = '0;
        pc = '0;
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        errBefore = errorCount;
        repeat (5) @(posedge clk);
        for (int i = 0; i < 32; i++) issueAlu(0, 1'b1, 5'(i), 5'(i), 5'd0, 12'd0, 0);
        drain();
        reportTest("reset and zero reads", errBefore);

        errBefore = errorCount;
        for (int r = 1; r < 32; r++) begin
            issueUpper(1'b0, 5'(r), 20'($urandom), MAX_GAP);
            issueAlu(0, 1'b1, 5'(r), 5'(r), 5'd0, 12'($urandom), MAX_GAP);
        end
        for (int i = 0; i < N_RAND; i++) begin
            code = $urandom % 10;
            issueAlu(code, (code != 1) && ($urandom % 2 == 1), randReg(), randReg(),
                     randReg(), 12'($urandom), MAX_GAP);
        end
        drain();
        reportTest("random ALU operations", errBefore);

        errBefore = errorCount;
        for (int i = 0; i < N_UPPER; i++) begin
            issueUpper(1'($urandom), randReg(), 20'($urandom), MAX_GAP);
        end
        drain();
        reportTest("LUI and AUIPC", errBefore);

        // Each step reads the rd just written and now and then x0
        errBefore = errorCount;
        prev = randReg();
        for (int i = 0; i < N_CHAIN; i++) begin
            code = $urandom % 10;
            rd = ($urandom % 4 == 0) ? 5'd0 : randReg();
            issueAlu(code, (code != 1) && ($urandom % 2 == 1), rd, prev, randReg(),
                     12'($urandom), 0);
            prev = rd;
        end
        drain();
        reportTest("dependent chains", errBefore);

        errBefore = errorCount;
        for (int i = 0; i < N_BRANCH; i++) begin
            rs1 = randReg();
            issueBranch($urandom % 6, rs1, ($urandom % 4 == 0) ? rs1 : randReg(),
                        13'($urandom), MAX_GAP);
        end
        readBackAll();
        drain();
        reportTest("branches", errBefore);

        errBefore = errorCount;
        for (int i = 0; i < N_ILLEGAL; i++) issueIllegal(MAX_GAP);
        readBackAll();
        drain();
        reportTest("illegal encodings", errBefore);

        $display("Checks passed %0d, errors %0d", passCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* execCore.f */
+incdir+include
logic/rv32Pkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/aluUnit.sv
logic/execCore.sv
bench/execCore_assert.sv
bench/execCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = execCoreTb
FILELIST  = execCore.f
OBJDIR    = obj_dir
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) include/rv32_params.svh

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
